// File: tb.f
+incdir+common
common/floor_pkg.sv
common/stack_if.sv
design/button_capture.sv
design/request_stack.sv
design/stopped_car_control.sv
design/floor_request_top.sv
verification/floor_checker.sv
verification/floor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run to a log, and decide the result from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module floor_tb \
    -Mdir "$BUILD_DIR" -o floor_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/floor_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG_FILE"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail, see $LOG_FILE"
exit 1

// File: verification/floor_tb.sv
// Seeded random stimulus changes on falling edges; current_floor stays within 0 to 10
`timescale 1ns/1ns
`include "floor_config.svh"

module floor_tb;

    localparam int CLOCK_PERIOD     = 40;
    localparam int RESET_CYCLES     = 10;
    localparam int IDLE_CYCLES      = 8;
    localparam int PRESS_CYCLES     = 400;
    localparam int SERVE_CYCLES     = 300;
    localparam int EMERGENCY_CYCLES = 200;
    localparam int POWER_CYCLES     = 300;
    localparam int TOTAL_CYCLES     = RESET_CYCLES + IDLE_CYCLES + PRESS_CYCLES + SERVE_CYCLES
                                    + EMERGENCY_CYCLES + POWER_CYCLES + 2;

    logic                       clock;
    logic                       reset_n;
    floor_pkg::floor_mask_t     floor_call_buttons;
    floor_pkg::floor_mask_t     panel_buttons;
    logic                       door_open_btn;
    logic                       door_close_btn;
    logic                       emergency_btn;
    logic                       power_switch;
    floor_pkg::floor_t          current_floor;
    floor_pkg::elevator_state_t elevator_state;
    logic                       elevator_direction;
    floor_pkg::floor_t          floor_selector;
    logic                       direction_selector;
    logic                       activate_elevator;
    floor_pkg::floor_mask_t     call_button_lights;
    floor_pkg::floor_mask_t     panel_button_lights;
    logic                       door_open_allowed;
    logic                       door_close_allowed;
    logic                       test_done;
    int                         test_index;
    logic                       run_done;
    int                         error_count;
    int                         seed;

    floor_request_top u_dut (.*);

    floor_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic int pick_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive_cycle(input int stop_pct, input int press_pct, input bit emergency,
                               input int power_off_pct, input bit seek_target, input bit doors);
        int floor_value;
        int state_code;
        bit park;
        // Parking on the offered floor gets it served
        // The other cycles leave the car elsewhere so the next entry is dispatched
        park        = seek_target && (pick_below(2) == 0);
        floor_value = park ? int'(floor_selector) : pick_below(`FLOOR_COUNT);
        if (pick_below(100) < stop_pct) begin
            state_code = floor_value;
        end else begin
            // Travel and emergency codes 11 to 31
            state_code = `FLOOR_COUNT + pick_below(21);
        end
        panel_buttons      = '0;
        floor_call_buttons = '0;
        if (pick_below(100) < press_pct) begin
            if (pick_below(2) == 0) begin
                if (pick_below(2) == 0) begin
                    panel_buttons = floor_pkg::floor_mask_t'(1) << pick_below(`FLOOR_COUNT);
                end else begin
                    floor_call_buttons = floor_pkg::floor_mask_t'(1) << pick_below(`FLOOR_COUNT);
                end
            end else begin
                panel_buttons      = floor_pkg::floor_mask_t'($random(seed) & $random(seed));
                floor_call_buttons = floor_pkg::floor_mask_t'($random(seed) & $random(seed));
            end
        end
        current_floor      = floor_pkg::floor_t'(floor_value);
        elevator_state     = floor_pkg::elevator_state_t'(`STATE_BITS'(state_code));
        elevator_direction = (pick_below(2) == 1);
        emergency_btn      = emergency;
        power_switch       = !(pick_below(100) < power_off_pct);
        door_open_btn      = doors && (pick_below(2) == 1);
        door_close_btn     = doors && (pick_below(2) == 1);
    endtask

    task automatic run_test(input int index, input int cycles, input int stop_pct,
                            input int press_pct, input bit emergency, input int power_off_pct,
                            input bit seek_target, input bit doors);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clock);
            drive_cycle(stop_pct, press_pct, emergency, power_off_pct, seek_target, doors);
            test_index = index;
            test_done  = (c == cycles - 1);
        end
    endtask

    initial begin
        seed               = 32'hb2e2;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        elevator_state     = floor_pkg::STOP_FL1;
        elevator_direction = 1'b0;
        test_done          = 1'b0;
        test_index         = 0;
        run_done           = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
        run_test(1, IDLE_CYCLES, 100, 0, 1'b0, 0, 1'b0, 1'b0);
        run_test(2, PRESS_CYCLES, 50, 70, 1'b0, 0, 1'b0, 1'b1);
        run_test(3, SERVE_CYCLES, 90, 30, 1'b0, 0, 1'b1, 1'b1);
        run_test(4, EMERGENCY_CYCLES, 80, 60, 1'b1, 0, 1'b0, 1'b1);
        run_test(5, POWER_CYCLES, 60, 60, 1'b0, 15, 1'b0, 1'b1);
        @(negedge clock);
        test_done = 1'b0;
        run_done  = 1'b1;
        @(negedge clock);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(2 * TOTAL_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verification/floor_checker.sv
// Model tracks stack and lights from the DUT ports; outputs are compared before each rising edge
`timescale 1ns/1ns
`include "floor_config.svh"

module floor_checker (
    input  logic                       clock,
    input  logic                       reset_n,
    input  floor_pkg::floor_mask_t     floor_call_buttons,
    input  floor_pkg::floor_mask_t     panel_buttons,
    input  logic                       door_open_btn,
    input  logic                       door_close_btn,
    input  logic                       emergency_btn,
    input  logic                       power_switch,
    input  floor_pkg::floor_t          current_floor,
    input  floor_pkg::elevator_state_t elevator_state,
    input  logic                       elevator_direction,
    input  floor_pkg::floor_t          floor_selector,
    input  logic                       direction_selector,
    input  logic                       activate_elevator,
    input  floor_pkg::floor_mask_t     call_button_lights,
    input  floor_pkg::floor_mask_t     panel_button_lights,
    input  logic                       door_open_allowed,
    input  logic                       door_close_allowed,
    input  logic                       test_done,
    input  int                         test_index,
    input  logic                       run_done,
    output int                         error_count
);

    int                     stack_model [`FLOOR_COUNT];
    int                     depth;
    floor_pkg::floor_mask_t panel_model;
    floor_pkg::floor_mask_t call_model;
    bit                     expect_pop;
    int                     check_count;
    int                     checks_base;
    int                     errors_base;
    int                     tests_run;
    bit                     counts_shown;

    initial begin
        depth        = 0;
        panel_model  = '0;
        call_model   = '0;
        expect_pop   = 1'b0;
        error_count  = 0;
        check_count  = 0;
        checks_base  = 0;
        errors_base  = 0;
        tests_run    = 0;
        counts_shown = 1'b0;
    end

    function automatic string test_name(input int index);
        case (index)
            1: return "reset and idle";
            2: return "random presses";
            3: return "serve floors";
            4: return "emergency hold";
            5: return "power drop";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
        end
    endtask

    ////////////////////
    // Expected outputs
    ////////////////////

    task automatic check_outputs();
        int cur;
        int top;
        bit stopped_on;
        bit has_entry;
        bit exp_activate;
        bit exp_direction;
        cur           = int'(current_floor);
        has_entry     = (depth > 0);
        top           = has_entry ? stack_model[depth - 1] : 0;
        // STOP codes are 0 to 10
        stopped_on    = power_switch && (int'(elevator_state) < `FLOOR_COUNT);
        exp_activate  = stopped_on && !emergency_btn && has_entry && (top != cur);
        exp_direction = exp_activate ? (top > cur) : elevator_direction;
        expect_pop    = stopped_on && has_entry && (top == cur);
        compare_value("floor_selector", has_entry ? top : cur, 32'(floor_selector));
        compare_value("activate_elevator", 32'(exp_activate), 32'(activate_elevator));
        compare_value("direction_selector", 32'(exp_direction), 32'(direction_selector));
        compare_value("panel_button_lights", 32'(panel_model), 32'(panel_button_lights));
        compare_value("call_button_lights", 32'(call_model), 32'(call_button_lights));
        compare_value("door_open_allowed", 32'(stopped_on && door_open_btn),
                      32'(door_open_allowed));
        compare_value("door_close_allowed", 32'(stopped_on && door_close_btn),
                      32'(door_close_allowed));
    endtask

    ////////////////////
    // Model update
    ////////////////////

    task automatic update_model();
        floor_pkg::floor_mask_t here;
        floor_pkg::floor_mask_t panel_ok;
        floor_pkg::floor_mask_t call_ok;
        int                     pick;
        bit                     from_panel;
        here       = floor_pkg::floor_mask_t'(1) << current_floor;
        panel_ok   = panel_buttons & ~here;
        call_ok    = floor_call_buttons & ~here;
        pick       = -1;
        from_panel = 1'b0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pick < 0 && panel_ok[i]) begin
                pick       = i;
                from_panel = 1'b1;
            end
        end
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pick < 0 && call_ok[i]) begin
                pick = i;
            end
        end
        if (!power_switch) begin
            depth       = 0;
            panel_model = '0;
            call_model  = '0;
        end else if (expect_pop) begin
            // Serving the floor, so no push this cycle
            depth       = depth - 1;
            panel_model = panel_model & ~here;
            call_model  = call_model & ~here;
        end else if (pick >= 0 && depth < `FLOOR_COUNT) begin
            stack_model[depth] = pick;
            depth              = depth + 1;
            if (from_panel) begin
                panel_model[pick] = 1'b1;
            end else begin
                call_model[pick] = 1'b1;
            end
        end
    endtask

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            depth       = 0;
            panel_model = '0;
            call_model  = '0;
        end else begin
            check_outputs();
            update_model();
            if (test_done) begin
                tests_run++;
                $display("Test %0d %s finished: %0d checks, %0d errors", test_index,
                         test_name(test_index), check_count - checks_base,
                         error_count - errors_base);
                checks_base = check_count;
                errors_base = error_count;
            end
            if (run_done && !counts_shown) begin
                counts_shown = 1'b1;
                $display("Totals: %0d tests, %0d checks, %0d errors", tests_run, check_count,
                         error_count);
            end
        end
    end

endmodule

// File: design/floor_request_top.sv
// Floors 0 to 10; power and emergency are plain levels and a full stack drops new presses
`timescale 1ns/1ns

module floor_request_top (
    input  logic                       clock,
    input  logic                       reset_n,
    input  floor_pkg::floor_mask_t     floor_call_buttons,
    input  floor_pkg::floor_mask_t     panel_buttons,
    input  logic                       door_open_btn,
    input  logic                       door_close_btn,
    input  logic                       emergency_btn,
    input  logic                       power_switch,
    input  floor_pkg::floor_t          current_floor,
    input  floor_pkg::elevator_state_t elevator_state,
    input  logic                       elevator_direction,
    output floor_pkg::floor_t          floor_selector,
    output logic                       direction_selector,
    output logic                       activate_elevator,
    output floor_pkg::floor_mask_t     call_button_lights,
    output floor_pkg::floor_mask_t     panel_button_lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    // Push, pop and stack status between the three blocks
    stack_if stack_bus ();

    button_capture u_capture (
        .clock               (clock),
        .reset_n             (reset_n),
        .power_switch        (power_switch),
        .panel_buttons       (panel_buttons),
        .floor_call_buttons  (floor_call_buttons),
        .current_floor       (current_floor),
        .bus                 (stack_bus.capture),
        .panel_button_lights (panel_button_lights),
        .call_button_lights  (call_button_lights)
    );

    request_stack u_stack (
        .clock        (clock),
        .reset_n      (reset_n),
        .power_switch (power_switch),
        .bus          (stack_bus.storage)
    );

    stopped_car_control u_control (
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .current_floor      (current_floor),
        .elevator_state     (elevator_state),
        .elevator_direction (elevator_direction),
        .bus                (stack_bus.dispatch),
        .floor_selector     (floor_selector),
        .direction_selector (direction_selector),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: design/stopped_car_control.sv
// Purely combinational; emergency blocks dispatch but not serving the floor the car stands at
`timescale 1ns/1ns

module stopped_car_control (
    input  logic                       power_switch,
    input  logic                       emergency_btn,
    input  logic                       door_open_btn,
    input  logic                       door_close_btn,
    input  floor_pkg::floor_t          current_floor,
    input  floor_pkg::elevator_state_t elevator_state,
    input  logic                       elevator_direction,
    stack_if.dispatch                  bus,
    output floor_pkg::floor_t          floor_selector,
    output logic                       direction_selector,
    output logic                       activate_elevator,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    logic stopped_on;
    logic at_target;

    assign stopped_on = power_switch && floor_pkg::is_stop_state(elevator_state);
    assign at_target  = (bus.top_floor == current_floor);

    // Next target, or stay put with nothing queued
    assign floor_selector = bus.empty ? current_floor : bus.top_floor;

    assign activate_elevator  = stopped_on && !emergency_btn && !bus.empty && !at_target;
    assign direction_selector = activate_elevator ? (bus.top_floor > current_floor)
                                                  : elevator_direction;

    // Arrived at the requested floor
    assign bus.pop = stopped_on && !bus.empty && at_target;

    // Doors only respond with the car standing and powered
    assign door_open_allowed  = stopped_on && door_open_btn;
    assign door_close_allowed = stopped_on && door_close_btn;

endmodule

// File: design/request_stack.sv
// Holds up to FLOOR_COUNT entries, duplicates allowed; pop wins over push and power off flushes
`timescale 1ns/1ns
`include "floor_config.svh"

module request_stack (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     power_switch,
    stack_if.storage bus
);

    // Pointer is the number of stored floors, also the next free slot
    logic [`FLOOR_BITS-1:0] pointer;
    floor_pkg::floor_t      entries [`FLOOR_COUNT];
    logic                   do_push;
    logic                   do_pop;

    assign bus.empty = (pointer == '0);
    assign bus.full  = (pointer == `FLOOR_BITS'(`FLOOR_COUNT));

    assign do_pop  = power_switch && bus.pop && !bus.empty;
    assign do_push = power_switch && bus.push && !bus.pop && !bus.full;

    // Most recent entry, zero when nothing is stored
    assign bus.top_floor = bus.empty ? '0 : entries[pointer - 1'b1];

    ////////////////////
    // Pointer
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pointer <= '0;
        end else if (!power_switch) begin
            pointer <= '0;
        end else if (do_pop) begin
            pointer <= pointer - 1'b1;
        end else if (do_push) begin
            pointer <= pointer + 1'b1;
        end
    end

    ////////////////////
    // Entry storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[pointer] <= bus.push_floor;
        end
    end

endmodule

// File: design/button_capture.sv
// One push per cycle at most; panel beats call, lowest floor wins, current floor presses are ignored
`timescale 1ns/1ns
`include "floor_config.svh"

module button_capture (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   power_switch,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_t      current_floor,
    stack_if.capture               bus,
    output floor_pkg::floor_mask_t panel_button_lights,
    output floor_pkg::floor_mask_t call_button_lights
);

    floor_pkg::floor_mask_t current_mask;
    floor_pkg::floor_mask_t panel_valid;
    floor_pkg::floor_mask_t call_valid;
    floor_pkg::floor_t      panel_pick;
    floor_pkg::floor_t      call_pick;
    logic                   panel_any;
    logic                   call_any;
    floor_pkg::floor_mask_t push_mask;
    floor_pkg::floor_mask_t clear_mask;

    // Index of the lowest set bit, zero when the mask is empty
    function automatic floor_pkg::floor_t lowest_set(input floor_pkg::floor_mask_t mask);
        floor_pkg::floor_t index;
        index = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (mask[i]) begin
                index = floor_pkg::floor_t'(i);
            end
        end
        return index;
    endfunction

    ////////////////////
    // Request select
    ////////////////////

    // The car is already here, so its own floor is masked off
    assign current_mask = floor_pkg::floor_mask_t'(1) << current_floor;
    assign panel_valid  = panel_buttons & ~current_mask;
    assign call_valid   = floor_call_buttons & ~current_mask;

    assign panel_any  = |panel_valid;
    assign call_any   = |call_valid;
    assign panel_pick = lowest_set(panel_valid);
    assign call_pick  = lowest_set(call_valid);

    // No push while serving a floor or with no room left
    assign bus.push       = power_switch && !bus.full && !bus.pop && (panel_any || call_any);
    assign bus.push_floor = panel_any ? panel_pick : call_pick;

    ////////////////////
    // Button lights
    ////////////////////

    assign push_mask  = bus.push ? (floor_pkg::floor_mask_t'(1) << bus.push_floor) : '0;
    assign clear_mask = bus.pop ? current_mask : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (!power_switch) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else begin
            // Pop and push never meet in one cycle
            panel_button_lights <= (panel_button_lights & ~clear_mask)
                                 | (panel_any ? push_mask : '0);
            call_button_lights  <= (call_button_lights & ~clear_mask)
                                 | (panel_any ? '0 : push_mask);
        end
    end

endmodule

// File: common/stack_if.sv
// Strobes are single-cycle levels with no handshake; push must never be raised with pop or full
`timescale 1ns/1ns

interface stack_if;

    // Request side
    logic              push;
    floor_pkg::floor_t push_floor;

    // Serve side
    logic              pop;

    // Stack status
    floor_pkg::floor_t top_floor;
    logic              full;
    logic              empty;

    modport capture (output push, output push_floor, input pop, input full);

    modport storage (
        input  push,
        input  push_floor,
        input  pop,
        output top_floor,
        output full,
        output empty
    );

    modport dispatch (output pop, input top_floor, input empty);

endinterface

// File: common/floor_pkg.sv
// Car state codes must match the car FSM encoding; only the STOP codes count as a stopped car
package floor_pkg;

    `include "floor_config.svh"

    ////////////////////
    // Floor types
    ////////////////////

    // Floor index, 0 is the lowest floor
    typedef logic [`FLOOR_BITS-1:0] floor_t;

    // One bit per floor, used for buttons and lights
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    ////////////////////
    // Car states
    ////////////////////

    // Codes run in sequence from the anchored values
    typedef enum logic [`STATE_BITS-1:0] {
        STOP_FL1 = 0,
        STOP_FL2,
        STOP_FL3,
        STOP_FL4,
        STOP_FL5,
        STOP_FL6,
        STOP_FL7,
        STOP_FL8,
        STOP_FL9,
        STOP_FL10,
        STOP_FL11,
        UP_F1_F2 = 11,
        UP_F2_F3,
        UP_F3_F4,
        UP_F4_F5,
        UP_F5_F6,
        UP_F6_F7,
        UP_F7_F8,
        UP_F8_F9,
        UP_F9_F10,
        UP_F10_F11,
        DOWN_F11_F10 = 21,
        DOWN_F10_F9,
        DOWN_F9_F8,
        DOWN_F8_F7,
        DOWN_F7_F6,
        DOWN_F6_F5,
        DOWN_F5_F4,
        DOWN_F4_F3,
        DOWN_F3_F2,
        DOWN_F2_F1,
        EMERGENCY = 31
    } elevator_state_t;

    // True while the car stands at any floor
    function automatic logic is_stop_state(input elevator_state_t state);
        return state inside {[STOP_FL1:STOP_FL11]};
    endfunction

endpackage

// File: common/floor_config.svh
// Eleven floors numbered 0 to 10; the index and car state widths must cover these counts
`ifndef FLOOR_CONFIG_SVH
`define FLOOR_CONFIG_SVH

////////////////////
// Building size
////////////////////

// Number of floors, also the request stack depth
`define FLOOR_COUNT 11

// Floor index width, wide enough to hold FLOOR_COUNT for the stack pointer
`define FLOOR_BITS 4

// Car state code width, matches the car FSM encoding
`define STATE_BITS 6

`endif
